// ==== hdl/ctrl_pkg.sv ====
package ctrl_pkg;

    // Primary opcode field
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_jal   = 6'h03,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_ble   = 6'h06,
        op_bgt   = 6'h07,
        op_addi  = 6'h08,
        op_addiu = 6'h09,
        op_slti  = 6'h0a,
        op_lui   = 6'h0f,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    // Function field, R-type only
    typedef enum logic [5:0] {
        fn_jr   = 6'h08,
        fn_mfhi = 6'h10,
        fn_mflo = 6'h12,
        fn_mult = 6'h18,
        fn_div  = 6'h1a,
        fn_add  = 6'h20,
        fn_sub  = 6'h22,
        fn_and  = 6'h24,
        fn_slt  = 6'h2a
    } funct_t;

    typedef enum logic [4:0] {
        cls_add, cls_sub, cls_and, cls_slt,
        cls_mult, cls_div, cls_jr, cls_mfhi, cls_mflo,
        cls_addi, cls_addiu, cls_slti, cls_lui,
        cls_beq, cls_bne, cls_ble, cls_bgt,
        cls_lw, cls_sw, cls_j, cls_jal,
        cls_illegal
    } instr_class_t;

    typedef enum logic [5:0] {
        st_sp_init,
        st_fetch1, st_fetch2, st_decode1, st_decode2, st_decode3, st_decode4,
        st_add, st_sub, st_and, st_save_rd,
        st_addi, st_save_rt, st_slt, st_slti, st_lui,
        st_beq, st_bne, st_bgt, st_ble,
        st_j, st_jal1, st_jal2, st_jr1, st_jr2,
        st_mem_addr, st_mem_read, st_mem_wait, st_mdr, st_lw, st_sw, st_sw_wait,
        st_mult_start, st_mult_wait, st_mult_save,
        st_div_start, st_div_wait, st_div_save,
        st_mfhi, st_mflo,
        st_illegal, st_div_zero, st_trap_addr_op, st_trap_addr_dz,
        st_trap_wait, st_trap_read, st_trap_jump
    } ctrl_state_t;

    typedef enum logic [2:0] {
        alu_pass    = 3'd0,
        alu_add     = 3'd1,
        alu_sub     = 3'd2,
        alu_and     = 3'd3,
        alu_compare = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        srcb_reg_b         = 2'd0,
        srcb_four          = 2'd1,
        srcb_imm           = 2'd2,
        srcb_branch_offset = 2'd3
    } alu_src_b_t;

    typedef enum logic [2:0] {
        pcsrc_alu_result       = 3'd0,
        pcsrc_aluout           = 3'd1,
        pcsrc_jump_target      = 3'd2,
        pcsrc_exception_vector = 3'd6
    } pc_source_t;

    typedef enum logic [2:0] {
        dst_rt = 3'd0,
        dst_sp = 3'd1,
        dst_ra = 3'd2,
        dst_rd = 3'd3
    } reg_dst_t;

    typedef enum logic [3:0] {
        m2r_aluout  = 4'd0,
        m2r_mdr     = 4'd1,
        m2r_hi      = 4'd2,
        m2r_lo      = 4'd3,
        m2r_sp_init = 4'd5,
        m2r_lui_imm = 4'd6,
        m2r_compare = 4'd8
    } mem_to_reg_t;

    typedef enum logic [2:0] {
        iord_pc              = 3'd0,
        iord_aluout          = 3'd1,
        iord_opcode_vector   = 3'd2,
        iord_div_zero_vector = 3'd4
    } iord_t;

    typedef enum logic [1:0] {
        br_eq = 2'd0,
        br_ne = 2'd1,
        br_gt = 2'd2,
        br_le = 2'd3
    } branch_op_t;

    typedef struct packed {
        logic        alu_src_a;   // 0 = PC, 1 = A
        alu_src_b_t  alu_src_b;
        alu_op_t     alu_op;
        pc_source_t  pc_source;
        reg_dst_t    reg_dst;
        mem_to_reg_t mem_to_reg;
        iord_t       iord;
        branch_op_t  branch_op;
        logic        hilo_sel;    // 1 = multiplier, 0 = divider
        logic        pc_write;
        logic        pc_write_cond;
        logic        ir_load;
        logic        ab_load;
        logic        aluout_load;
        logic        reg_write;
        logic        mem_write;
        logic        mdr_load;
        logic        epc_load;
        logic        hilo_load;
        logic        mult_start;
        logic        div_start;
    } ctrl_word_t;

endpackage

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  ctrl_pkg::opcode_t      op,
    input  ctrl_pkg::funct_t       funct,
    output ctrl_pkg::instr_class_t instr_class
);
    import ctrl_pkg::*;

    instr_class_t rtype_class;

    // R-type is resolved on the function field
    always_comb begin
        case (funct)
            fn_add:  rtype_class = cls_add;
            fn_sub:  rtype_class = cls_sub;
            fn_and:  rtype_class = cls_and;
            fn_slt:  rtype_class = cls_slt;
            fn_mult: rtype_class = cls_mult;
            fn_div:  rtype_class = cls_div;
            fn_jr:   rtype_class = cls_jr;
            fn_mfhi: rtype_class = cls_mfhi;
            fn_mflo: rtype_class = cls_mflo;
            default: rtype_class = cls_illegal;
        endcase
    end

    always_comb begin
        case (op)
            op_rtype: instr_class = rtype_class;
            op_addi:  instr_class = cls_addi;
            op_addiu: instr_class = cls_addiu;
            op_slti:  instr_class = cls_slti;
            op_lui:   instr_class = cls_lui;
            op_beq:   instr_class = cls_beq;
            op_bne:   instr_class = cls_bne;
            op_ble:   instr_class = cls_ble;
            op_bgt:   instr_class = cls_bgt;
            op_lw:    instr_class = cls_lw;
            op_sw:    instr_class = cls_sw;
            op_j:     instr_class = cls_j;
            op_jal:   instr_class = cls_jal;
            default:  instr_class = cls_illegal;   // Unknown opcode
        endcase
    end

endmodule

// ==== hdl/ctrl_sequencer.sv ====
`timescale 1ns/1ps

module ctrl_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  ctrl_pkg::instr_class_t instr_class,
    input  logic                   div_zero,
    input  logic                   div_done,
    input  logic                   mult_done,
    output ctrl_pkg::ctrl_state_t  state
);
    import ctrl_pkg::*;

    ctrl_state_t  next_state;
    instr_class_t cls_q;    // Class held for the execute phase

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_sp_init;
            cls_q <= cls_illegal;
        end else begin
            state <= next_state;
            if (state == st_decode4) begin
                cls_q <= instr_class;
            end
        end
    end

    // Dispatch out of decode4
    function automatic ctrl_state_t dispatch(input instr_class_t cls);
        case (cls)
            cls_add:   return st_add;
            cls_sub:   return st_sub;
            cls_and:   return st_and;
            cls_slt:   return st_slt;
            cls_addi:  return st_addi;
            cls_addiu: return st_addi;
            cls_slti:  return st_slti;
            cls_lui:   return st_lui;
            cls_beq:   return st_beq;
            cls_bne:   return st_bne;
            cls_bgt:   return st_bgt;
            cls_ble:   return st_ble;
            cls_j:     return st_j;
            cls_jal:   return st_jal1;
            cls_jr:    return st_jr1;
            cls_lw:    return st_mem_addr;
            cls_sw:    return st_mem_addr;
            cls_mult:  return st_mult_start;
            cls_div:   return st_div_start;
            cls_mfhi:  return st_mfhi;
            cls_mflo:  return st_mflo;
            default:   return st_illegal;
        endcase
    endfunction

    always_comb begin
        next_state = st_fetch1;
        case (state)
            st_sp_init: next_state = st_fetch1;
            st_fetch1:  next_state = st_fetch2;
            st_fetch2:  next_state = st_decode1;
            st_decode1: next_state = st_decode2;
            st_decode2: next_state = st_decode3;
            st_decode3: next_state = st_decode4;
            st_decode4: next_state = dispatch(instr_class);

            st_add, st_sub, st_and: next_state = st_save_rd;
            st_addi:                next_state = st_save_rt;

            st_jal1: next_state = st_jal2;
            st_jal2: next_state = st_j;
            st_jr1:  next_state = st_jr2;

            st_mem_addr: next_state = st_mem_read;
            st_mem_read: next_state = st_mem_wait;
            st_mem_wait: next_state = st_mdr;
            st_mdr:      next_state = (cls_q == cls_sw) ? st_sw : st_lw;
            st_sw:       next_state = st_sw_wait;

            st_mult_start: next_state = st_mult_wait;
            st_mult_wait: begin
                next_state = mult_done ? st_mult_save : st_mult_wait;
            end

            st_div_start: next_state = st_div_wait;
            st_div_wait: begin
                if (div_zero) begin
                    next_state = st_div_zero;   // Zero divisor wins over done
                end else if (div_done) begin
                    next_state = st_div_save;
                end else begin
                    next_state = st_div_wait;
                end
            end

            // Exception entry, then the shared tail
            st_illegal:      next_state = st_trap_addr_op;
            st_div_zero:     next_state = st_trap_addr_dz;
            st_trap_addr_op: next_state = st_trap_wait;
            st_trap_addr_dz: next_state = st_trap_wait;
            st_trap_wait:    next_state = st_trap_read;
            st_trap_read:    next_state = st_trap_jump;

            default: next_state = st_fetch1;   // Last execute cycle
        endcase
    end

endmodule

// ==== hdl/ctrl_word_table.sv ====
`timescale 1ns/1ps

module ctrl_word_table (
    input  ctrl_pkg::ctrl_state_t state,
    output ctrl_pkg::ctrl_word_t  ctrl
);
    import ctrl_pkg::*;

    always_comb begin
        ctrl = '0;
        case (state)
            st_sp_init: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = dst_sp;
                ctrl.mem_to_reg = m2r_sp_init;
            end
            st_fetch1: ctrl.iord = iord_pc;
            st_fetch2: begin
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = pcsrc_alu_result;
                ctrl.alu_src_b = srcb_four;     // PC + 4
                ctrl.alu_op    = alu_add;
            end
            st_decode1: ctrl.ir_load = 1'b1;
            st_decode2: ctrl.ab_load = 1'b1;
            st_decode3: begin
                ctrl.aluout_load = 1'b1;        // Branch target ahead of time
                ctrl.alu_src_b   = srcb_branch_offset;
                ctrl.alu_op      = alu_add;
            end
            st_add, st_sub, st_and, st_addi: begin
                ctrl.alu_src_a   = 1'b1;
                ctrl.alu_src_b   = (state == st_addi) ? srcb_imm : srcb_reg_b;
                ctrl.aluout_load = 1'b1;
                case (state)
                    st_sub:  ctrl.alu_op = alu_sub;
                    st_and:  ctrl.alu_op = alu_and;
                    default: ctrl.alu_op = alu_add;
                endcase
            end
            st_save_rd, st_save_rt, st_jal2: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = m2r_aluout;
                case (state)
                    st_save_rd: ctrl.reg_dst = dst_rd;
                    st_jal2:    ctrl.reg_dst = dst_ra;   // Return address
                    default:    ctrl.reg_dst = dst_rt;
                endcase
            end
            st_slt, st_slti: begin
                ctrl.alu_src_a  = 1'b1;
                ctrl.alu_src_b  = (state == st_slti) ? srcb_imm : srcb_reg_b;
                ctrl.alu_op     = alu_compare;
                ctrl.mem_to_reg = m2r_compare;
                ctrl.reg_dst    = (state == st_slti) ? dst_rt : dst_rd;
                ctrl.reg_write  = 1'b1;
            end
            st_lui: begin
                ctrl.mem_to_reg = m2r_lui_imm;
                ctrl.reg_dst    = dst_rt;
                ctrl.reg_write  = 1'b1;
            end
            st_beq, st_bne, st_bgt, st_ble: begin
                ctrl.pc_write_cond = 1'b1;
                ctrl.alu_src_a     = 1'b1;
                ctrl.alu_src_b     = srcb_reg_b;
                ctrl.alu_op        = alu_compare;
                ctrl.pc_source     = pcsrc_aluout;
                case (state)
                    st_bne:  ctrl.branch_op = br_ne;
                    st_bgt:  ctrl.branch_op = br_gt;
                    st_ble:  ctrl.branch_op = br_le;
                    default: ctrl.branch_op = br_eq;
                endcase
            end
            st_j: begin
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = pcsrc_jump_target;
            end
            st_jal1: begin
                ctrl.aluout_load = 1'b1;        // Pass PC through
                ctrl.alu_op      = alu_pass;
            end
            st_jr1, st_jr2: begin
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_op    = alu_pass;
                ctrl.pc_write  = (state == st_jr2);
                ctrl.pc_source = pcsrc_alu_result;
            end
            st_mem_addr: begin
                ctrl.alu_src_a   = 1'b1;
                ctrl.alu_src_b   = srcb_imm;
                ctrl.alu_op      = alu_add;
                ctrl.aluout_load = 1'b1;
            end
            st_mem_read, st_mem_wait, st_sw_wait: ctrl.iord = iord_aluout;
            st_mdr: begin
                ctrl.iord     = iord_aluout;
                ctrl.mdr_load = 1'b1;
            end
            st_lw: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = m2r_mdr;
                ctrl.reg_dst    = dst_rt;
            end
            st_sw: begin
                ctrl.mem_write = 1'b1;
                ctrl.iord      = iord_aluout;
            end
            st_mult_start: ctrl.mult_start = 1'b1;
            st_div_start:  ctrl.div_start = 1'b1;
            st_mult_save, st_div_save: begin
                ctrl.hilo_load = 1'b1;
                ctrl.hilo_sel  = (state == st_mult_save);
            end
            st_mfhi, st_mflo: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = dst_rd;
                ctrl.mem_to_reg = (state == st_mfhi) ? m2r_hi : m2r_lo;
            end
            st_illegal, st_div_zero: begin
                ctrl.epc_load  = 1'b1;          // EPC = PC - 4
                ctrl.alu_src_b = srcb_four;
                ctrl.alu_op    = alu_sub;
            end
            st_trap_addr_op: ctrl.iord = iord_opcode_vector;
            st_trap_addr_dz: ctrl.iord = iord_div_zero_vector;
            st_trap_read:    ctrl.mdr_load = 1'b1;
            st_trap_jump: begin
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = pcsrc_exception_vector;
            end
            default: ctrl = '0;   // decode4, waits
        endcase
    end

endmodule

// ==== hdl/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic                clk,
    input  logic                reset,
    input  ctrl_pkg::opcode_t   op,
    input  ctrl_pkg::funct_t    funct,
    input  logic                div_zero,
    input  logic                div_done,
    input  logic                mult_done,
    output ctrl_pkg::ctrl_word_t ctrl
);
    import ctrl_pkg::*;

    instr_class_t instr_class;
    ctrl_state_t  state;

    instr_decoder instr_decoder_i (
        .op          (op),
        .funct       (funct),
        .instr_class (instr_class)
    );

    ctrl_sequencer ctrl_sequencer_i (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .div_zero    (div_zero),
        .div_done    (div_done),
        .mult_done   (mult_done),
        .state       (state)
    );

    // Moore outputs straight from the state
    ctrl_word_table ctrl_word_table_i (
        .state (state),
        .ctrl  (ctrl)
    );

endmodule

// ==== bench/control_unit_props.sv ====
`timescale 1ns/1ps

module control_unit_props (
    input logic                 clk,
    input logic                 reset,
    input ctrl_pkg::opcode_t    op,
    input ctrl_pkg::funct_t     funct,
    input logic                 div_zero,
    input logic                 div_done,
    input logic                 mult_done,
    input ctrl_pkg::ctrl_word_t ctrl
);
    import ctrl_pkg::*;

    localparam logic [6:0] ev_write = 7'b100_0000;  // reg_write outside sp init
    localparam logic [6:0] ev_cond  = 7'b010_0000;
    localparam logic [6:0] ev_jump  = 7'b001_0000;  // pc_write outside fetch
    localparam logic [6:0] ev_store = 7'b000_1000;
    localparam logic [6:0] ev_mdr   = 7'b000_0100;
    localparam logic [6:0] ev_epc   = 7'b000_0010;
    localparam logic [6:0] ev_hilo  = 7'b000_0001;
    localparam logic [6:0] ev_trap  = ev_epc | ev_mdr | ev_jump;

    int unsigned error_count = 0;
    int unsigned gap;        // Cycles since the last ir_load
    int unsigned exp_gap;    // 0 when the length is not fixed
    logic [6:0]  exp_write;  // {reg_dst, mem_to_reg}
    pc_source_t  exp_pc;
    branch_op_t  exp_br;
    logic        is_sw;
    logic        trap;
    logic [11:0] strobes;
    logic [6:0]  events;     // Execute strobes of this cycle
    logic [6:0]  seen;       // Execute strobes since ab_load
    logic [6:0]  exp_events;

    assign strobes = {ctrl.pc_write, ctrl.pc_write_cond, ctrl.ir_load, ctrl.ab_load,
                      ctrl.aluout_load, ctrl.reg_write, ctrl.mem_write, ctrl.mdr_load,
                      ctrl.epc_load, ctrl.hilo_load, ctrl.mult_start, ctrl.div_start};

    assign events = {ctrl.reg_write && ctrl.reg_dst != dst_sp, ctrl.pc_write_cond,
                     ctrl.pc_write && ctrl.alu_src_b != srcb_four, ctrl.mem_write,
                     ctrl.mdr_load, ctrl.epc_load, ctrl.hilo_load};

    // Expected behavior of the instruction, captured once op is stable
    always_ff @(posedge clk) begin
        if (reset) begin
            gap        <= 0;
            exp_gap    <= 0;
            trap       <= 1'b0;
            seen       <= '0;
            exp_events <= '0;
        end else begin
            gap  <= ctrl.ir_load ? 1 : gap + 1;
            seen <= seen | events;
            if (div_zero) begin
                trap <= 1'b1;
            end
            if (ctrl.ab_load) begin
                trap       <= 1'b0;
                seen       <= '0;
                exp_gap    <= 0;
                exp_write  <= '0;
                exp_pc     <= pcsrc_jump_target;
                exp_br     <= br_eq;
                exp_events <= ev_write;   // Most classes end in a register write
                is_sw      <= (op == op_sw);
                case (op)
                    op_rtype: begin
                        case (funct)
                            fn_add, fn_sub, fn_and: begin
                                exp_gap   <= 8;
                                exp_write <= {dst_rd, m2r_aluout};
                            end
                            fn_slt: begin
                                exp_gap   <= 7;
                                exp_write <= {dst_rd, m2r_compare};
                            end
                            fn_mfhi: begin
                                exp_gap   <= 7;
                                exp_write <= {dst_rd, m2r_hi};
                            end
                            fn_mflo: begin
                                exp_gap   <= 7;
                                exp_write <= {dst_rd, m2r_lo};
                            end
                            fn_jr: begin
                                exp_gap    <= 8;
                                exp_pc     <= pcsrc_alu_result;
                                exp_events <= ev_jump;
                            end
                            fn_mult, fn_div: begin
                                exp_gap    <= 0;   // Length set by done
                                exp_events <= ev_hilo;
                            end
                            default: begin
                                exp_gap    <= 11;
                                trap       <= 1'b1;
                                exp_events <= ev_trap;
                            end
                        endcase
                    end
                    op_addi, op_addiu: begin
                        exp_gap   <= 8;
                        exp_write <= {dst_rt, m2r_aluout};
                    end
                    op_slti: begin
                        exp_gap   <= 7;
                        exp_write <= {dst_rt, m2r_compare};
                    end
                    op_lui: begin
                        exp_gap   <= 7;
                        exp_write <= {dst_rt, m2r_lui_imm};
                    end
                    op_beq: begin
                        exp_gap    <= 7;
                        exp_events <= ev_cond;
                    end
                    op_bne: begin
                        exp_gap    <= 7;
                        exp_br     <= br_ne;
                        exp_events <= ev_cond;
                    end
                    op_bgt: begin
                        exp_gap    <= 7;
                        exp_br     <= br_gt;
                        exp_events <= ev_cond;
                    end
                    op_ble: begin
                        exp_gap    <= 7;
                        exp_br     <= br_le;
                        exp_events <= ev_cond;
                    end
                    op_j: begin
                        exp_gap    <= 7;
                        exp_events <= ev_jump;
                    end
                    op_jal: begin
                        exp_gap    <= 9;
                        exp_write  <= {dst_ra, m2r_aluout};
                        exp_events <= ev_write | ev_jump;
                    end
                    op_lw: begin
                        exp_gap    <= 11;
                        exp_write  <= {dst_rt, m2r_mdr};
                        exp_events <= ev_write | ev_mdr;
                    end
                    op_sw: begin
                        exp_gap    <= 12;
                        exp_events <= ev_store | ev_mdr;
                    end
                    default: begin
                        exp_gap    <= 11;
                        trap       <= 1'b1;
                        exp_events <= ev_trap;
                    end
                endcase
            end
        end
    end

    sp_init_then_fetch: assert property (@(posedge clk) $fell(reset) |->
        (strobes == 12'h040 && ctrl.reg_dst == dst_sp && ctrl.mem_to_reg == m2r_sp_init)
        ##1 (strobes == 12'h000))
    else begin
        $error("ERROR %0t strobes got %h expected 040 then 000", $time, strobes);
        error_count++;
    end

    fetch_then_ir_load: assert property (@(posedge clk) disable iff (reset)
        ctrl.ir_load |-> $past(ctrl.pc_write) && $past(ctrl.alu_src_b) == srcb_four)
    else begin
        $error("ir_load at %0t came without the PC + 4 write one cycle earlier", $time);
        error_count++;
    end

    instr_length: assert property (@(posedge clk) disable iff (reset)
        ctrl.ir_load && exp_gap != 0 |-> gap == exp_gap)
    else begin
        $error("ERROR %0t ir_load gap got %0d expected %0d", $time, gap, exp_gap);
        error_count++;
    end

    instr_events: assert property (@(posedge clk) disable iff (reset)
        ctrl.ir_load |-> seen == (trap ? ev_trap : exp_events))
    else begin
        $error("ERROR %0t execute strobes got %b expected %b", $time, seen,
               trap ? ev_trap : exp_events);
        error_count++;
    end

    write_target: assert property (@(posedge clk) disable iff (reset)
        ctrl.reg_write && ctrl.reg_dst != dst_sp |->
        {ctrl.reg_dst, ctrl.mem_to_reg} == exp_write)
    else begin
        $error("ERROR %0t {reg_dst,mem_to_reg} got %h expected %h", $time,
               {ctrl.reg_dst, ctrl.mem_to_reg}, exp_write);
        error_count++;
    end

    write_is_last: assert property (@(posedge clk) disable iff (reset)
        ctrl.reg_write && ctrl.reg_dst != dst_sp && ctrl.reg_dst != dst_ra |=>
        ctrl == '0)
    else begin
        $error("ERROR %0t ctrl after write got %h expected 0", $time, ctrl);
        error_count++;
    end

    branch_once: assert property (@(posedge clk) disable iff (reset)
        ctrl.pc_write_cond |->
        (ctrl.branch_op == exp_br && ctrl.pc_source == pcsrc_aluout) ##1 !ctrl.pc_write_cond)
    else begin
        $error("ERROR %0t branch_op got %0d expected %0d", $time, ctrl.branch_op, exp_br);
        error_count++;
    end

    jump_source: assert property (@(posedge clk) disable iff (reset)
        ctrl.pc_write && ctrl.alu_src_b != srcb_four |->
        ctrl.pc_source == (trap ? pcsrc_exception_vector : exp_pc))
    else begin
        $error("ERROR %0t pc_source got %0d expected %0d", $time, ctrl.pc_source,
               trap ? pcsrc_exception_vector : exp_pc);
        error_count++;
    end

    sw_writes_once: assert property (@(posedge clk) disable iff (reset)
        ctrl.mdr_load && ctrl.iord == iord_aluout && is_sw |=>
        ctrl.mem_write ##1 !ctrl.mem_write)
    else begin
        $error("ERROR %0t mem_write got %0b after mdr_load of sw", $time, ctrl.mem_write);
        error_count++;
    end

    lw_writes_mdr: assert property (@(posedge clk) disable iff (reset)
        ctrl.mdr_load && ctrl.iord == iord_aluout && !is_sw |=>
        ctrl.reg_write && ctrl.mem_to_reg == m2r_mdr)
    else begin
        $error("ERROR %0t mem_to_reg got %0d expected %0d", $time, ctrl.mem_to_reg, m2r_mdr);
        error_count++;
    end

    start_one_cycle: assert property (@(posedge clk) disable iff (reset)
        ctrl.mult_start || ctrl.div_start |=> !ctrl.mult_start && !ctrl.div_start)
    else begin
        $error("ERROR %0t start pulse got 1 expected 0 in second cycle", $time);
        error_count++;
    end

    mult_save: assert property (@(posedge clk) disable iff (reset)
        mult_done |=> ctrl.hilo_load && ctrl.hilo_sel)
    else begin
        $error("ERROR %0t hilo_load got %0b hilo_sel got %0b expected 1 1", $time,
               ctrl.hilo_load, ctrl.hilo_sel);
        error_count++;
    end

    div_save: assert property (@(posedge clk) disable iff (reset)
        div_done && !div_zero |=> ctrl.hilo_load && !ctrl.hilo_sel)
    else begin
        $error("ERROR %0t hilo_load got %0b hilo_sel got %0b expected 1 0", $time,
               ctrl.hilo_load, ctrl.hilo_sel);
        error_count++;
    end

    no_save_on_trap: assert property (@(posedge clk) disable iff (reset)
        ctrl.hilo_load |-> !trap)
    else begin
        $error("ERROR %0t hilo_load got 1 expected 0 during exception", $time);
        error_count++;
    end

    trap_sequence: assert property (@(posedge clk) disable iff (reset)
        ctrl.epc_load |-> trap ##4
        (ctrl.pc_write && ctrl.pc_source == pcsrc_exception_vector))
    else begin
        $error("ERROR %0t pc_source got %0d expected %0d four cycles after epc_load",
               $time, ctrl.pc_source, pcsrc_exception_vector);
        error_count++;
    end

endmodule

bind control_unit control_unit_props props_i (
    .clk       (clk),
    .reset     (reset),
    .op        (op),
    .funct     (funct),
    .div_zero  (div_zero),
    .div_done  (div_done),
    .mult_done (mult_done),
    .ctrl      (ctrl)
);

// ==== bench/control_unit_tb.sv ====
`timescale 1ns/1ps

module control_unit_tb;
    import ctrl_pkg::*;

    logic       clk = 1'b0;
    logic       reset;
    opcode_t    op;
    funct_t     funct;
    logic       div_zero;
    logic       div_done;
    logic       mult_done;
    ctrl_word_t ctrl;

    integer     seed;
    opcode_t    prog_op[$];
    funct_t     prog_fn[$];
    int         zero_div_index;

    always #20 clk = ~clk;

    control_unit control_unit_i (
        .clk       (clk),
        .reset     (reset),
        .op        (op),
        .funct     (funct),
        .div_zero  (div_zero),
        .div_done  (div_done),
        .mult_done (mult_done),
        .ctrl      (ctrl)
    );

    // Stop at the first failed assertion
    always @(negedge clk) begin
        if (control_unit_i.props_i.error_count != 0) begin
            $display(">>> FAIL");
            $fatal(1, "an assertion on the control word failed");
        end
    end

    task automatic add_instr(input opcode_t o, input funct_t f);
        prog_op.push_back(o);
        prog_fn.push_back(f);
    endtask

    task automatic stop_on_timeout(input string what);
        $display(">>> FAIL");
        $fatal(1, "timeout while waiting for %s", what);
    endtask

    task automatic wait_ir_load();
        int n;
        n = 0;
        @(posedge clk);
        while (!ctrl.ir_load) begin
            n++;
            if (n > 100) begin
                stop_on_timeout("ir_load");
            end
            @(posedge clk);
        end
    endtask

    task automatic wait_start();
        int n;
        n = 0;
        @(posedge clk);
        while (!(ctrl.mult_start || ctrl.div_start)) begin
            n++;
            if (n > 20) begin
                stop_on_timeout("mult_start or div_start");
            end
            @(posedge clk);
        end
    endtask

    // Multiplier or divider model, answers after 0 to 7 wait cycles
    task automatic answer_unit(input logic is_mult, input logic zero);
        int delay;
        wait_start();
        delay = $unsigned($random(seed)) % 8;
        repeat (delay) @(posedge clk);
        if (zero) begin
            div_zero <= 1'b1;
        end else if (is_mult) begin
            mult_done <= 1'b1;
        end else begin
            div_done <= 1'b1;
        end
        @(posedge clk);
        div_zero  <= 1'b0;
        div_done  <= 1'b0;
        mult_done <= 1'b0;
    endtask

    initial begin
        seed      = 32'h7476_6cbd;
        reset     = 1'b1;
        op        = op_rtype;
        funct     = fn_add;
        div_zero  = 1'b0;
        div_done  = 1'b0;
        mult_done = 1'b0;

        add_instr(op_rtype, fn_add);
        add_instr(op_rtype, fn_sub);
        add_instr(op_rtype, fn_and);
        add_instr(op_rtype, fn_slt);
        add_instr(op_addi, fn_add);
        add_instr(op_addiu, fn_add);
        add_instr(op_slti, fn_add);
        add_instr(op_lui, fn_add);
        add_instr(op_beq, fn_add);
        add_instr(op_bne, fn_add);
        add_instr(op_bgt, fn_add);
        add_instr(op_ble, fn_add);
        add_instr(op_j, fn_add);
        add_instr(op_jal, fn_add);
        add_instr(op_rtype, fn_jr);
        add_instr(op_lw, fn_add);
        add_instr(op_sw, fn_add);
        add_instr(op_rtype, fn_mult);
        add_instr(op_rtype, fn_mfhi);
        add_instr(op_rtype, fn_div);
        add_instr(op_rtype, fn_mflo);
        add_instr(op_rtype, fn_div);    // Divisor of zero
        zero_div_index = prog_op.size() - 1;
        add_instr(opcode_t'(6'h3f), fn_add);
        add_instr(op_rtype, fn_add);

        repeat (16) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < prog_op.size(); i++) begin
            wait_ir_load();
            op    <= prog_op[i];
            funct <= prog_fn[i];
            if (prog_op[i] == op_rtype && (prog_fn[i] == fn_mult || prog_fn[i] == fn_div)) begin
                answer_unit(prog_fn[i] == fn_mult, i == zero_div_index);
            end
        end
        wait_ir_load();
        repeat (2) @(posedge clk);

        if (control_unit_i.props_i.error_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "assertions on the control word failed");
        end
    end

endmodule

// ==== build.f ====
hdl/ctrl_pkg.sv
hdl/instr_decoder.sv
hdl/ctrl_sequencer.sv
hdl/ctrl_word_table.sv
hdl/control_unit.sv
bench/control_unit_props.sv
bench/control_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
    --top-module control_unit_tb \
    -f build.f \
    -o control_unit_sim

./obj_dir/control_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
grep -q ">>> PASS" sim.log
